//--- all.f
+incdir+.
lcd_pkg.sv
lcd_timing.sv
vram_arbiter.sv
pattern_fill.sv
apb_vram_port.sv
scanout.sv
lcd_top.sv
lcd_properties.sv
lcd_tb.sv

//--- apb_vram_port.sv
module apb_vram_port (
	input  logic                pixel_clk,
	input  logic                rst,

	input  logic                psel,
	input  logic                penable,
	input  logic                pwrite,
	input  lcd_pkg::vram_addr_t paddr,
	input  lcd_pkg::pixel_t     pwdata,
	output lcd_pkg::pixel_t     prdata,
	output logic                pready,

	output logic                host_req,
	output logic                host_we,
	output lcd_pkg::vram_addr_t host_addr,
	output lcd_pkg::pixel_t     host_wdata,
	input  logic                host_gnt,
	input  lcd_pkg::pixel_t     rdata
);
	import lcd_pkg::*;

	logic   pending;
	pixel_t rd_hold;

	// request during the access phase until the ram is won once.
	assign host_req   = psel && penable && !pending;
	assign host_we    = pwrite;
	assign host_addr  = paddr;
	assign host_wdata = pwdata;

	always_ff @(posedge pixel_clk or negedge rst) begin
		if (!rst) begin
			pending <= 1'b0;
		end else if (host_gnt) begin
			pending <= 1'b1;
		end else if (!penable) begin
			pending <= 1'b0; // access phase is over.
		end
	end

	always_ff @(posedge pixel_clk or negedge rst) begin
		if (!rst) begin
			pready <= 1'b0;
		end else begin
			pready <= host_gnt; // one cycle, right after the grant.
		end
	end

	always_ff @(posedge pixel_clk) begin
		if (pready && !pwrite) begin
			rd_hold <= rdata;
		end
	end

	// ram read data is live while pready is high, held afterwards.
	assign prdata = pready ? rdata : rd_hold;

endmodule

//--- lcd_defines.svh
`ifndef LCD_DEFINES_SVH
`define LCD_DEFINES_SVH

// horizontal timing in pixels.
`define H_ACTIVE 64
`define H_FRONT  4
`define H_SYNC   4
`define H_BACK   8
`define H_TOTAL  (`H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK)

// vertical timing in lines.
`define V_ACTIVE 48
`define V_FRONT  2
`define V_SYNC   2
`define V_BACK   4
`define V_TOTAL  (`V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK)

`define START_X 16 // ram window in active coordinates.
`define STOP_X  48
`define START_Y 8
`define STOP_Y  40

`define SCALE_SHIFT 1 // one word per 2x2 pixels.

`define VRAM_ADDR_BITS 8
`define VRAM_WORDS     (1 << `VRAM_ADDR_BITS)

`endif

//--- lcd_pkg.sv
`include "lcd_defines.svh"

package lcd_pkg;

	// rgb565 word, used for ram contents, apb data and colour.
	typedef logic [15:0] pixel_t;

	// pixel or line count.
	typedef logic [15:0] coord_t;

	typedef logic [`VRAM_ADDR_BITS-1:0] vram_addr_t;

	// requester index, in falling priority.
	typedef enum logic [1:0] {
		REQ_SCAN = 2'd0,
		REQ_FILL = 2'd1,
		REQ_HOST = 2'd2
	} req_id_t;

endpackage

//--- lcd_properties.sv
module lcd_properties (
	input logic pixel_clk,
	input logic rst,
	input logic scan_req,
	input logic fill_req,
	input logic host_req,
	input logic scan_gnt,
	input logic fill_gnt,
	input logic host_gnt
);
	timeunit 1ns;
	timeprecision 100ps;

	int violations = 0;

	grant_exclusive: assert property (@(posedge pixel_clk) disable iff (!rst)
		$onehot0({scan_gnt, fill_gnt, host_gnt}))
	else begin
		violations++;
		$error("more than one grant in the same cycle");
	end

	// a grant only follows its own request.
	grant_has_request: assert property (@(posedge pixel_clk) disable iff (!rst)
		(!scan_gnt || scan_req) &&
		(!fill_gnt || fill_req) &&
		(!host_gnt || host_req))
	else begin
		violations++;
		$error("grant given without its request");
	end

	scan_never_waits: assert property (@(posedge pixel_clk) disable iff (!rst)
		scan_req |-> scan_gnt)
	else begin
		violations++;
		$error("scan request not granted in the same cycle");
	end

endmodule

bind vram_arbiter lcd_properties i_lcd_properties (
	.pixel_clk (pixel_clk),
	.rst       (rst),
	.scan_req  (scan_req),
	.fill_req  (fill_req),
	.host_req  (host_req),
	.scan_gnt  (scan_gnt),
	.fill_gnt  (fill_gnt),
	.host_gnt  (host_gnt)
);

//--- lcd_tb.sv
`include "lcd_defines.svh"

module lcd_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import lcd_pkg::*;

	localparam int FRAME_CYCLES   = `H_TOTAL * `V_TOTAL;
	localparam int FRAME_PIXELS   = `H_ACTIVE * `V_ACTIVE;
	localparam int TIMEOUT_CYCLES = 40000; // roughly twice the length of all tests.

	logic       pixel_clk;
	logic       rst;
	logic       psel;
	logic       penable;
	logic       pwrite;
	vram_addr_t paddr;
	pixel_t     pwdata;
	pixel_t     prdata;
	logic       pready;
	logic       fill_done;
	logic [4:0] lcd_r;
	logic [5:0] lcd_g;
	logic [4:0] lcd_b;
	logic       lcd_den;
	logic       lcd_hsync;
	logic       lcd_vsync;

	pixel_t model [`VRAM_WORDS]; // expected ram contents.
	pixel_t written [`VRAM_WORDS];
	logic   was_written [`VRAM_WORDS];
	int     cycle_count;
	int     checks_passed;
	int     checks_failed;

	lcd_top i_lcd_top (
		.pixel_clk (pixel_clk),
		.rst       (rst),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.pready    (pready),
		.fill_done (fill_done),
		.lcd_r     (lcd_r),
		.lcd_g     (lcd_g),
		.lcd_b     (lcd_b),
		.lcd_den   (lcd_den),
		.lcd_hsync (lcd_hsync),
		.lcd_vsync (lcd_vsync)
	);

	initial begin
		pixel_clk = 1'b0;
		forever #50 pixel_clk = ~pixel_clk;
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge pixel_clk);
			cycle_count++;
		end
		$display("run stopped after %0d cycles because a test did not finish", TIMEOUT_CYCLES);
		$display("Some tests failed");
		$finish;
	end

	task automatic check_pixel(input string name, input pixel_t expected, input pixel_t actual);
		if (actual === expected) begin
			checks_passed++;
		end else begin
			checks_failed++;
			$display("CHECK FAILED %s expected 0x%04h actual 0x%04h", name, expected, actual);
		end
	endtask

	task automatic check_data(input string name, input pixel_t expected, input pixel_t actual);
		if (actual === expected) begin
			checks_passed++;
		end else begin
			checks_failed++;
			$display("CHECK FAILED %s expected 0x%04h actual 0x%04h", name, expected, actual);
		end
	endtask

	task automatic check_count(input string name, input int expected, input int actual);
		if (actual == expected) begin
			checks_passed++;
		end else begin
			checks_failed++;
			$display("CHECK FAILED %s expected 0x%0h actual 0x%0h", name, expected, actual);
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual === expected) begin
			checks_passed++;
		end else begin
			checks_failed++;
			$display("CHECK FAILED %s expected 0x%0h actual 0x%0h", name, expected, actual);
		end
	endtask

	task automatic report_test(input string name, input int fails_before);
		if (checks_failed == fails_before) begin
			$display("test %s passed", name);
		end else begin
			$display("test %s failed with %0d errors", name, checks_failed - fails_before);
		end
	endtask

	// address in the high byte, its inverse in the low byte.
	function automatic pixel_t fill_word(input vram_addr_t addr);
		return pixel_t'(int'(addr) * 256 + (255 - int'(addr)));
	endfunction

	function automatic logic in_window(input int col, input int row);
		return col >= `START_X && col < `STOP_X && row >= `START_Y && row < `STOP_Y;
	endfunction

	// row cell in the high nibble, column cell in the low nibble.
	function automatic vram_addr_t window_addr(input int col, input int row);
		return vram_addr_t'((((row - `START_Y) >> `SCALE_SHIFT) * 16) +
			((col - `START_X) >> `SCALE_SHIFT));
	endfunction

	function automatic pixel_t expected_pixel(input int col, input int row);
		if (in_window(col, row)) begin
			return model[window_addr(col, row)];
		end
		return pixel_t'(col + row); // background.
	endfunction

	task automatic apb_transfer(input logic write, input vram_addr_t addr, input pixel_t data,
		output pixel_t rd);
		@(negedge pixel_clk);
		psel    = 1'b1; // setup phase.
		penable = 1'b0;
		pwrite  = write;
		paddr   = addr;
		pwdata  = data;
		@(negedge pixel_clk);
		penable = 1'b1;
		@(negedge pixel_clk);
		while (pready !== 1'b1) begin
			@(negedge pixel_clk);
		end
		rd = prdata;
		@(negedge pixel_clk); // transfer completed on the last rising edge.
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apb_write(input vram_addr_t addr, input pixel_t data);
		pixel_t unused;
		apb_transfer(1'b1, addr, data, unused);
	endtask

	task automatic apb_read(input vram_addr_t addr, output pixel_t data);
		apb_transfer(1'b0, addr, '0, data);
	endtask

	// returns on the first sample with vsync low.
	task automatic wait_frame_start();
		@(negedge pixel_clk);
		while (lcd_vsync !== 1'b1) begin
			@(negedge pixel_clk);
		end
		while (lcd_vsync !== 1'b0) begin
			@(negedge pixel_clk);
		end
	endtask

	task automatic test_reset_and_timing();
		int fails_before;
		int den_cycles;
		int hs_pulses;
		int hs_run;
		int vs_low;
		fails_before = checks_failed;
		check_flag("pready", 1'b0, pready);
		check_flag("fill_done", 1'b0, fill_done);
		check_flag("lcd_den", 1'b0, lcd_den);
		check_pixel("lcd rgb", '0, {lcd_r, lcd_g, lcd_b});
		check_flag("lcd_hsync", 1'b1, lcd_hsync);
		check_flag("lcd_vsync", 1'b1, lcd_vsync);
		den_cycles = 0;
		hs_pulses  = 0;
		hs_run     = 0;
		vs_low     = 0;
		wait_frame_start();
		for (int i = 0; i < FRAME_CYCLES; i++) begin
			if (lcd_den) den_cycles++;
			if (!lcd_vsync) vs_low++;
			if (!lcd_hsync) begin
				hs_run++;
			end else if (hs_run > 0) begin
				hs_pulses++;
				check_count("hsync pulse length", `H_SYNC, hs_run);
				hs_run = 0;
			end
			@(negedge pixel_clk);
		end
		check_count("lcd_den cycles", FRAME_PIXELS, den_cycles);
		check_count("hsync pulses", `V_TOTAL, hs_pulses);
		check_count("vsync low cycles", `V_SYNC * `H_TOTAL, vs_low);
		report_test("reset and frame timing", fails_before);
	endtask

	task automatic test_fill_pattern();
		int         fails_before;
		vram_addr_t addr;
		pixel_t     data;
		fails_before = checks_failed;
		while (fill_done !== 1'b1) begin
			@(negedge pixel_clk);
		end
		for (int i = 0; i < 16; i++) begin
			addr = vram_addr_t'($urandom);
			apb_read(addr, data);
			check_data($sformatf("prdata[0x%02h]", addr), fill_word(addr), data);
		end
		report_test("fill pattern readback", fails_before);
	endtask

	task automatic test_host_writes();
		int         fails_before;
		vram_addr_t addr;
		pixel_t     data;
		vram_addr_t addrs[$];
		fails_before = checks_failed;
		wait_frame_start();
		// start inside the window rows, so scanout forces wait states.
		for (int line = 0; line < `START_Y + 2; line++) begin
			while (lcd_den !== 1'b0) begin
				@(negedge pixel_clk);
			end
			while (lcd_den !== 1'b1) begin
				@(negedge pixel_clk);
			end
		end
		for (int i = 0; i < 20; i++) begin
			addr = vram_addr_t'($urandom);
			data = pixel_t'($urandom);
			apb_write(addr, data);
			model[addr]       = data;
			written[addr]     = data;
			was_written[addr] = 1'b1;
			addrs.push_back(addr);
		end
		foreach (addrs[i]) begin
			apb_read(addrs[i], data);
			check_data($sformatf("prdata[0x%02h]", addrs[i]), model[addrs[i]], data);
		end
		report_test("host writes and readback", fails_before);
	endtask

	task automatic test_frame_content();
		int fails_before;
		int n;
		int col;
		int row;
		fails_before = checks_failed;
		wait_frame_start();
		n = 0;
		while (n < FRAME_PIXELS) begin
			@(negedge pixel_clk);
			if (lcd_den) begin
				col = n % `H_ACTIVE;
				row = n / `H_ACTIVE;
				check_pixel($sformatf("lcd rgb at x %0d y %0d", col, row),
					expected_pixel(col, row), {lcd_r, lcd_g, lcd_b});
				n++;
			end else begin
				check_pixel("lcd rgb outside enable", '0, {lcd_r, lcd_g, lcd_b});
			end
		end
		report_test("frame content", fails_before);
	endtask

	task automatic test_new_words_shown();
		int fails_before;
		int n;
		int col;
		int row;
		int seen;
		int expected_seen;
		fails_before  = checks_failed;
		expected_seen = 0;
		for (int a = 0; a < `VRAM_WORDS; a++) begin
			if (was_written[vram_addr_t'(a)]) expected_seen += 1 << (2 * `SCALE_SHIFT);
		end
		wait_frame_start();
		n    = 0;
		seen = 0;
		while (n < `H_ACTIVE * `STOP_Y) begin // window rows end here.
			@(negedge pixel_clk);
			if (lcd_den) begin
				col = n % `H_ACTIVE;
				row = n / `H_ACTIVE;
				if (in_window(col, row) && was_written[window_addr(col, row)]) begin
					check_pixel($sformatf("lcd rgb at x %0d y %0d", col, row),
						written[window_addr(col, row)], {lcd_r, lcd_g, lcd_b});
					seen++;
				end
				n++;
			end
		end
		check_count("written pixels shown", expected_seen, seen);
		check_flag("fill_done", 1'b1, fill_done);
		report_test("new words on screen", fails_before);
	endtask

	initial begin
		int assert_fails;
		void'($urandom(2));
		rst           = 1'b0;
		psel          = 1'b0;
		penable       = 1'b0;
		pwrite        = 1'b0;
		paddr         = '0;
		pwdata        = '0;
		checks_passed = 0;
		checks_failed = 0;
		for (int a = 0; a < `VRAM_WORDS; a++) begin
			model[vram_addr_t'(a)]       = fill_word(vram_addr_t'(a));
			written[vram_addr_t'(a)]     = '0;
			was_written[vram_addr_t'(a)] = 1'b0;
		end
		repeat (16) @(negedge pixel_clk);
		rst = 1'b1;
		test_reset_and_timing();
		test_fill_pattern();
		test_host_writes();
		test_frame_content();
		test_new_words_shown();
		assert_fails = i_lcd_top.i_vram_arbiter.i_lcd_properties.violations;
		$display("checks passed %0d, checks failed %0d, assertion failures %0d",
			checks_passed, checks_failed, assert_fails);
		if (checks_failed == 0 && assert_fails == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

//--- lcd_timing.sv
`include "lcd_defines.svh"

module lcd_timing (
	input  logic            pixel_clk,
	input  logic            rst,
	output lcd_pkg::coord_t x,
	output lcd_pkg::coord_t y,
	output logic            active,
	output logic            hsync,
	output logic            vsync
);
	import lcd_pkg::*;

	localparam coord_t H_LAST   = coord_t'(`H_TOTAL - 1);
	localparam coord_t V_LAST   = coord_t'(`V_TOTAL - 1);
	localparam coord_t H_ACT    = coord_t'(`H_ACTIVE);
	localparam coord_t V_ACT    = coord_t'(`V_ACTIVE);
	localparam coord_t HS_START = coord_t'(`H_ACTIVE + `H_FRONT);
	localparam coord_t HS_STOP  = coord_t'(`H_ACTIVE + `H_FRONT + `H_SYNC);
	localparam coord_t VS_START = coord_t'(`V_ACTIVE + `V_FRONT);
	localparam coord_t VS_STOP  = coord_t'(`V_ACTIVE + `V_FRONT + `V_SYNC);

	coord_t h_cnt;
	coord_t v_cnt;
	logic   h_wrap;

	assign h_wrap = (h_cnt == H_LAST);

	always_ff @(posedge pixel_clk or negedge rst) begin
		if (!rst) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (h_wrap) begin
			h_cnt <= '0;
			if (v_cnt == V_LAST) begin
				v_cnt <= '0;
			end else begin
				v_cnt <= v_cnt + 16'd1;
			end
		end else begin
			h_cnt <= h_cnt + 16'd1;
		end
	end

	// all outputs come from the same counter state, so they stay aligned.
	always_ff @(posedge pixel_clk or negedge rst) begin
		if (!rst) begin
			x      <= '0;
			y      <= '0;
			active <= 1'b0;
			hsync  <= 1'b1;
			vsync  <= 1'b1;
		end else begin
			x      <= h_cnt;
			y      <= v_cnt;
			active <= (h_cnt < H_ACT) && (v_cnt < V_ACT);
			hsync  <= !((h_cnt >= HS_START) && (h_cnt < HS_STOP)); // active low.
			vsync  <= !((v_cnt >= VS_START) && (v_cnt < VS_STOP)); // whole lines.
		end
	end

endmodule

//--- lcd_top.sv
module lcd_top (
	input  logic                pixel_clk,
	input  logic                rst,

	input  logic                psel,
	input  logic                penable,
	input  logic                pwrite,
	input  lcd_pkg::vram_addr_t paddr,
	input  lcd_pkg::pixel_t     pwdata,
	output lcd_pkg::pixel_t     prdata,
	output logic                pready,

	output logic                fill_done,

	output logic [4:0]          lcd_r,
	output logic [5:0]          lcd_g,
	output logic [4:0]          lcd_b,
	output logic                lcd_den,
	output logic                lcd_hsync,
	output logic                lcd_vsync
);
	import lcd_pkg::*;

	coord_t     x;
	coord_t     y;
	logic       active;
	logic       hsync;
	logic       vsync;

	logic       scan_req;
	vram_addr_t scan_addr;
	logic       scan_gnt;
	logic       fill_req;
	vram_addr_t fill_addr;
	pixel_t     fill_wdata;
	logic       fill_gnt;
	logic       host_req;
	logic       host_we;
	vram_addr_t host_addr;
	pixel_t     host_wdata;
	logic       host_gnt;
	pixel_t     rdata; // shared by scanout and the apb port.

	lcd_timing i_lcd_timing (
		.pixel_clk (pixel_clk),
		.rst       (rst),
		.x         (x),
		.y         (y),
		.active    (active),
		.hsync     (hsync),
		.vsync     (vsync)
	);

	scanout i_scanout (
		.pixel_clk (pixel_clk),
		.rst       (rst),
		.x         (x),
		.y         (y),
		.active    (active),
		.hsync_in  (hsync),
		.vsync_in  (vsync),
		.scan_req  (scan_req),
		.scan_addr (scan_addr),
		.scan_gnt  (scan_gnt),
		.rdata     (rdata),
		.lcd_r     (lcd_r),
		.lcd_g     (lcd_g),
		.lcd_b     (lcd_b),
		.lcd_den   (lcd_den),
		.lcd_hsync (lcd_hsync),
		.lcd_vsync (lcd_vsync)
	);

	pattern_fill i_pattern_fill (
		.pixel_clk  (pixel_clk),
		.rst        (rst),
		.fill_req   (fill_req),
		.fill_addr  (fill_addr),
		.fill_wdata (fill_wdata),
		.fill_gnt   (fill_gnt),
		.fill_done  (fill_done)
	);

	apb_vram_port i_apb_vram_port (
		.pixel_clk  (pixel_clk),
		.rst        (rst),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.paddr      (paddr),
		.pwdata     (pwdata),
		.prdata     (prdata),
		.pready     (pready),
		.host_req   (host_req),
		.host_we    (host_we),
		.host_addr  (host_addr),
		.host_wdata (host_wdata),
		.host_gnt   (host_gnt),
		.rdata      (rdata)
	);

	vram_arbiter i_vram_arbiter (
		.pixel_clk  (pixel_clk),
		.rst        (rst),
		.scan_req   (scan_req),
		.scan_addr  (scan_addr),
		.scan_gnt   (scan_gnt),
		.fill_req   (fill_req),
		.fill_addr  (fill_addr),
		.fill_wdata (fill_wdata),
		.fill_gnt   (fill_gnt),
		.host_req   (host_req),
		.host_we    (host_we),
		.host_addr  (host_addr),
		.host_wdata (host_wdata),
		.host_gnt   (host_gnt),
		.rdata      (rdata)
	);

endmodule

//--- pattern_fill.sv
module pattern_fill (
	input  logic                pixel_clk,
	input  logic                rst,
	output logic                fill_req,
	output lcd_pkg::vram_addr_t fill_addr,
	output lcd_pkg::pixel_t     fill_wdata,
	input  logic                fill_gnt,
	output logic                fill_done
);
	import lcd_pkg::*;

	localparam vram_addr_t LAST_ADDR = '1;

	logic filling;

	always_ff @(posedge pixel_clk or negedge rst) begin
		if (!rst) begin
			filling   <= 1'b1; // starts straight out of reset.
			fill_addr <= '0;
		end else if (filling && fill_gnt) begin
			fill_addr <= fill_addr + vram_addr_t'(1);
			if (fill_addr == LAST_ADDR) begin
				filling <= 1'b0;
			end
		end
	end

	assign fill_req = filling;

	// address in the high byte, its inverse in the low byte.
	assign fill_wdata = {fill_addr, ~fill_addr};

	assign fill_done = !filling; // stays high until the next reset.

endmodule

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module lcd_tb \
	-Mdir obj_dir -f all.f \
	&& ./obj_dir/Vlcd_tb +verilator+error+limit+100 | tee sim.log
grep -qx "All tests passed" sim.log 2>/dev/null \
	&& echo "simulation passed" \
	|| { echo "simulation did not pass"; exit 1; }

//--- scanout.sv
`include "lcd_defines.svh"

module scanout (
	input  logic                pixel_clk,
	input  logic                rst,
	input  lcd_pkg::coord_t     x,
	input  lcd_pkg::coord_t     y,
	input  logic                active,
	input  logic                hsync_in,
	input  logic                vsync_in,

	output logic                scan_req,
	output lcd_pkg::vram_addr_t scan_addr,
	input  logic                scan_gnt,
	input  lcd_pkg::pixel_t     rdata,

	output logic [4:0]          lcd_r,
	output logic [5:0]          lcd_g,
	output logic [4:0]          lcd_b,
	output logic                lcd_den,
	output logic                lcd_hsync,
	output logic                lcd_vsync
);
	import lcd_pkg::*;

	localparam coord_t WIN_X0 = coord_t'(`START_X);
	localparam coord_t WIN_X1 = coord_t'(`STOP_X);
	localparam coord_t WIN_Y0 = coord_t'(`START_Y);
	localparam coord_t WIN_Y1 = coord_t'(`STOP_Y);

	coord_t col_cell;
	coord_t row_cell;
	logic   in_win;

	logic   win_q; // stage 1.
	logic   den_q;
	logic   hs_q;
	logic   vs_q;
	pixel_t bg_q;
	pixel_t pix_q; // stage 2.

	assign in_win = active && (x >= WIN_X0) && (x < WIN_X1) && (y >= WIN_Y0) && (y < WIN_Y1);

	assign col_cell = (x - WIN_X0) >> `SCALE_SHIFT;
	assign row_cell = (y - WIN_Y0) >> `SCALE_SHIFT;

	assign scan_req  = in_win;
	assign scan_addr = {row_cell[3:0], col_cell[3:0]};

	always_ff @(posedge pixel_clk or negedge rst) begin
		if (!rst) begin
			win_q     <= 1'b0;
			den_q     <= 1'b0;
			hs_q      <= 1'b1;
			vs_q      <= 1'b1;
			pix_q     <= '0;
			lcd_den   <= 1'b0;
			lcd_hsync <= 1'b1;
			lcd_vsync <= 1'b1;
		end else begin
			win_q     <= scan_gnt; // ram word arrives next cycle.
			den_q     <= active;
			hs_q      <= hsync_in;
			vs_q      <= vsync_in;
			pix_q     <= den_q ? (win_q ? rdata : bg_q) : '0;
			lcd_den   <= den_q;
			lcd_hsync <= hs_q;
			lcd_vsync <= vs_q;
		end
	end

	always_ff @(posedge pixel_clk) begin
		bg_q <= x + y;
	end

	assign lcd_r = pix_q[15:11];
	assign lcd_g = pix_q[10:5];
	assign lcd_b = pix_q[4:0];

endmodule

//--- vram_arbiter.sv
`include "lcd_defines.svh"

module vram_arbiter (
	input  logic                pixel_clk,
	input  logic                rst,

	input  logic                scan_req,
	input  lcd_pkg::vram_addr_t scan_addr,
	output logic                scan_gnt,

	input  logic                fill_req,
	input  lcd_pkg::vram_addr_t fill_addr,
	input  lcd_pkg::pixel_t     fill_wdata,
	output logic                fill_gnt,

	input  logic                host_req,
	input  logic                host_we,
	input  lcd_pkg::vram_addr_t host_addr,
	input  lcd_pkg::pixel_t     host_wdata,
	output logic                host_gnt,

	output lcd_pkg::pixel_t     rdata
);
	import lcd_pkg::*;

	pixel_t     mem [`VRAM_WORDS];
	req_id_t    sel;
	logic       any_req;
	vram_addr_t addr;
	logic       we;
	pixel_t     wdata;

	// fixed priority, scan first.
	always_comb begin
		if (scan_req) begin
			sel = REQ_SCAN;
		end else if (fill_req) begin
			sel = REQ_FILL;
		end else begin
			sel = REQ_HOST;
		end
	end

	assign any_req  = scan_req | fill_req | host_req;
	assign scan_gnt = scan_req;
	assign fill_gnt = (sel == REQ_FILL);
	assign host_gnt = (sel == REQ_HOST) && host_req;

	always_comb begin
		case (sel)
			REQ_SCAN: begin
				addr  = scan_addr;
				we    = 1'b0; // scanout only reads.
				wdata = '0;
			end
			REQ_FILL: begin
				addr  = fill_addr;
				we    = 1'b1;
				wdata = fill_wdata;
			end
			default: begin
				addr  = host_addr;
				we    = host_we;
				wdata = host_wdata;
			end
		endcase
	end

	always_ff @(posedge pixel_clk) begin
		if (any_req && we) begin
			mem[addr] <= wdata;
		end
	end

	// read data shows up the cycle after the grant.
	always_ff @(posedge pixel_clk or negedge rst) begin
		if (!rst) begin
			rdata <= '0;
		end else if (any_req && !we) begin
			rdata <= mem[addr];
		end
	end

endmodule
